/* chan_adacq.f */
src/adacq_pkg.sv
src/acq_timebase.sv
src/chan_acq_ctrl.sv
src/adc_spi_rd.sv
src/chan_adacq_top.sv
dv/adc_model.sv
dv/chan_adacq_tb.sv

/* dv/chan_adacq_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module chan_adacq_tb import adacq_pkg::*; ();

    logic             clk_sys;
    logic             rst_sys_n;
    logic             pw_on_en;
    logic             cal_model_en;
    logic             cfg_chn_enable;
    logic             spi_sdo;
    logic             spi_cs_n;
    logic             spi_sclk;
    logic             ch_ad_diag;
    logic             acq_dgdad_en;
    logic [ADC_W-1:0] ch_ad_value;
    logic             value_upd;
    logic             ad_acq_cpl;
    logic [ADC_W-1:0] chan_sample;
    logic [ADC_W-1:0] diag_sample;

    logic [31:0]      lcg_state;
    int unsigned      err_cnt;
    int unsigned      cyc = 0;
    // monitor enables
    bit               cpl_seen;
    bit               quiet_chk;
    bit               cal_chk;
    logic [ADC_W-1:0] held_val;

    chan_adacq_top u_chan_adacq_top (
        .clk_sys        (clk_sys),
        .rst_sys_n      (rst_sys_n),
        .pw_on_en       (pw_on_en),
        .cal_model_en   (cal_model_en),
        .cfg_chn_enable (cfg_chn_enable),
        .spi_sdo        (spi_sdo),
        .spi_cs_n       (spi_cs_n),
        .spi_sclk       (spi_sclk),
        .ch_ad_diag     (ch_ad_diag),
        .acq_dgdad_en   (acq_dgdad_en),
        .ch_ad_value    (ch_ad_value),
        .value_upd      (value_upd),
        .ad_acq_cpl     (ad_acq_cpl)
    );

    adc_model u_adc_model (
        .spi_cs_n    (spi_cs_n),
        .spi_sclk    (spi_sclk),
        .ch_ad_diag  (ch_ad_diag),
        .chan_sample (chan_sample),
        .diag_sample (diag_sample),
        .spi_sdo     (spi_sdo)
    );

    // 40 ns period
    initial begin
        clk_sys = 1'b0;
        forever #20 clk_sys = ~clk_sys;
    end

    always @(posedge clk_sys) begin
        cyc <= cyc + 1;
    end

    // ------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------
    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // caller picks the sign bit
    // random magnitude
    function automatic logic [ADC_W-1:0] next_word(input logic sign);
        lcg_state = lcg_step(lcg_state);
        return {sign, lcg_state[30:16]};
    endfunction

    // negative codes read as zero
    // positive codes keep their offset above half scale
    function automatic logic [ADC_W-1:0] clip_expect(input logic [ADC_W-1:0] w);
        int unsigned half_scale;
        half_scale = 1 << (ADC_W - 1);
        if (w < half_scale) begin
            return '0;
        end
        return ADC_W'(w - half_scale);
    endfunction

    function automatic int unsigned acq_cycles(input int unsigned n);
        return n * ACQ_PERIOD_TICKS * (TICK_DIV + 1);
    endfunction

    function automatic logic sig_level(input string name);
        if (name == "value_upd") return value_upd;
        else if (name == "ch_ad_diag") return ch_ad_diag;
        else if (name == "spi_cs_n") return spi_cs_n;
        else return ad_acq_cpl;
    endfunction

    task automatic check_val(input string sig, input logic [ADC_W-1:0] got,
                             input logic [ADC_W-1:0] exp);
        assert (got === exp) else begin
            $display("FAIL t=%0t %s got 0x%0h exp 0x%0h", $time, sig, got, exp);
            err_cnt++;
        end
    endtask

    // sampled on the falling edge
    // gives up after limit cycles
    task automatic wait_level(input string name, input logic lvl,
                              input int unsigned limit, output bit ok);
        int unsigned n;
        n  = 0;
        ok = 1'b0;
        while (!ok && n < limit) begin
            @(negedge clk_sys);
            ok = (sig_level(name) === lvl);
            n++;
        end
        assert (ok) else begin
            $display("timeout after %0d cycles waiting for %s to reach %0b", limit, name, lvl);
            err_cnt++;
        end
    endtask

    task automatic check_idle_outputs();
        check_val("spi_cs_n", spi_cs_n, 1'b1);
        check_val("spi_sclk", spi_sclk, 1'b0);
        check_val("ch_ad_value", ch_ad_value, '0);
        check_val("ad_acq_cpl", ad_acq_cpl, 1'b0);
        check_val("value_upd", value_upd, 1'b0);
        check_val("ch_ad_diag", ch_ad_diag, 1'b0);
    endtask

    // continuous checks gated by the running test
    always @(negedge clk_sys) begin
        check_val("acq_dgdad_en", acq_dgdad_en, ch_ad_diag);
        if (cpl_seen) begin
            check_val("ad_acq_cpl", ad_acq_cpl, 1'b1);
        end
        if (quiet_chk) begin
            check_val("value_upd", value_upd, 1'b0);
            check_val("ch_ad_value", ch_ad_value, held_val);
        end
        if (cal_chk) begin
            check_val("ch_ad_diag", ch_ad_diag, 1'b0);
        end
    end

    // ------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------
    task automatic test_reset();
        @(posedge clk_sys);
        rst_sys_n <= 1'b0;
        repeat (3) begin
            @(negedge clk_sys);
            check_idle_outputs();
            @(posedge clk_sys);
        end
        rst_sys_n <= 1'b1;
        @(negedge clk_sys);
        check_idle_outputs();
    endtask

    task automatic test_normal();
        bit               ok;
        logic [ADC_W-1:0] w;
        w = next_word(1'b1);
        @(posedge clk_sys);
        chan_sample    <= w;
        diag_sample    <= next_word(1'b1);
        pw_on_en       <= 1'b1;
        cfg_chn_enable <= 1'b1;
        // first trigger plus one conversion
        wait_level("value_upd", 1'b1, acq_cycles(5), ok);
        check_val("ch_ad_value", ch_ad_value, clip_expect(w));
        wait_level("ad_acq_cpl", 1'b1, 4, ok);
        cpl_seen = ok;
    endtask

    task automatic test_clip_neg();
        bit               ok;
        logic [ADC_W-1:0] w;
        w = next_word(1'b0);
        @(posedge clk_sys);
        chan_sample <= w;
        wait_level("value_upd", 1'b1, acq_cycles(5), ok);
        check_val("ch_ad_value", ch_ad_value, clip_expect(w));
    endtask

    task automatic test_chan_off();
        @(posedge clk_sys);
        cfg_chn_enable <= 1'b0;
        repeat (acq_cycles(3)) begin
            @(negedge clk_sys);
            check_val("spi_cs_n", spi_cs_n, 1'b1);
            check_val("value_upd", value_upd, 1'b0);
        end
    endtask

    task automatic test_diag();
        bit               ok;
        logic [ADC_W-1:0] w;
        @(posedge clk_sys);
        cfg_chn_enable <= 1'b1;
        // one diag period plus one acquisition period
        wait_level("ch_ad_diag", 1'b1,
                   (DIAG_PERIOD_TICKS + ACQ_PERIOD_TICKS) * (TICK_DIV + 1), ok);
        held_val  = ch_ad_value;
        quiet_chk = 1'b1;
        @(posedge clk_sys);
        chan_sample <= next_word(1'b1);
        diag_sample <= next_word(1'b1);
        wait_level("ch_ad_diag", 1'b0, acq_cycles(6), ok);
        // switch-back frame is discarded as well
        wait_level("spi_cs_n", 1'b0, acq_cycles(4), ok);
        wait_level("spi_cs_n", 1'b1, acq_cycles(4), ok);
        repeat (4) @(negedge clk_sys);
        quiet_chk = 1'b0;
        w = next_word(1'b1);
        @(posedge clk_sys);
        chan_sample <= w;
        // the next diag request may come due before a clean read
        wait_level("value_upd", 1'b1, acq_cycles(10), ok);
        check_val("ch_ad_value", ch_ad_value, clip_expect(w));
    endtask

    task automatic test_cal();
        bit               ok;
        logic [ADC_W-1:0] w;
        int unsigned      start;
        @(posedge clk_sys);
        cal_model_en   <= 1'b1;
        cfg_chn_enable <= 1'b0;
        // mux release takes one cycle
        @(posedge clk_sys);
        @(negedge clk_sys);
        cal_chk = 1'b1;
        start   = cyc;
        ok      = 1'b1;
        while (ok && (cyc - start) < (DIAG_PERIOD_TICKS + ACQ_PERIOD_TICKS) * (TICK_DIV + 1)) begin
            w = next_word(1'b1);
            @(posedge clk_sys);
            chan_sample <= w;
            wait_level("value_upd", 1'b1, acq_cycles(6), ok);
            if (ok) begin
                check_val("ch_ad_value", ch_ad_value, clip_expect(w));
            end
        end
        cal_chk = 1'b0;
    endtask

    // ------------------------------------------------------------
    // sequence
    // ------------------------------------------------------------
    initial begin
        rst_sys_n      = 1'b1;
        pw_on_en       = 1'b0;
        cal_model_en   = 1'b0;
        cfg_chn_enable = 1'b0;
        chan_sample    = '0;
        diag_sample    = '0;
        lcg_state      = 32'd8;
        err_cnt        = 0;
        cpl_seen       = 1'b0;
        quiet_chk      = 1'b0;
        cal_chk        = 1'b0;
        held_val       = '0;

        test_reset();
        test_normal();
        test_clip_neg();
        test_chan_off();
        test_diag();
        test_cal();

        $display("summary: %0d errors", err_cnt);
        if (err_cnt == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* dv/adc_model.sv */
`timescale 1ns/1ps
`default_nettype none

module adc_model import adacq_pkg::*; (
    input  logic             spi_cs_n,
    input  logic             spi_sclk,
    input  logic             ch_ad_diag,
    input  logic [ADC_W-1:0] chan_sample,
    input  logic [ADC_W-1:0] diag_sample,
    output logic             spi_sdo
);

    // word being shifted out, msb on the line
    logic [ADC_W-1:0] word_q   = '0;
    // set once the word for this frame is loaded
    logic             in_frame = 1'b0;

    // ------------------------------------------------------------
    // mode 0 slave
    // ------------------------------------------------------------
    // cs fall loads, sclk fall moves to the next bit
    // master samples on the rising edge in between
    always @(negedge spi_cs_n or posedge spi_cs_n or negedge spi_sclk) begin
        if (spi_cs_n) begin
            in_frame <= 1'b0;
        end else if (!in_frame) begin
            in_frame <= 1'b1;
            // mux position picks the source for the whole frame
            word_q   <= ch_ad_diag ? diag_sample : chan_sample;
        end else begin
            word_q   <= {word_q[ADC_W-2:0], 1'b0};
        end
    end

    assign spi_sdo = word_q[ADC_W-1];

endmodule

`default_nettype wire

/* src/chan_adacq_top.sv */
`timescale 1ns/1ps
`default_nettype none

module chan_adacq_top import adacq_pkg::*; (
    input  logic             clk_sys,
    input  logic             rst_sys_n,
    input  logic             pw_on_en,
    input  logic             cal_model_en,
    input  logic             cfg_chn_enable,
    input  logic             spi_sdo,
    output logic             spi_cs_n,
    output logic             spi_sclk,
    output logic             ch_ad_diag,
    output logic             acq_dgdad_en,
    output logic [ADC_W-1:0] ch_ad_value,
    output logic             value_upd,
    output logic             ad_acq_cpl
);

    // ------------------------------------------------------------
    // internal links
    // ------------------------------------------------------------
    tick_bus_t ticks;
    adc_rd_t   adc;
    logic      rd_en;

    // trigger and diag period generation
    acq_timebase u_acq_timebase (
        .clk_sys   (clk_sys),
        .rst_sys_n (rst_sys_n),
        .pw_on_en  (pw_on_en),
        .ticks     (ticks)
    );

    // sequencing, mux select and result
    chan_acq_ctrl u_chan_acq_ctrl (
        .clk_sys        (clk_sys),
        .rst_sys_n      (rst_sys_n),
        .pw_on_en       (pw_on_en),
        .cal_model_en   (cal_model_en),
        .cfg_chn_enable (cfg_chn_enable),
        .ticks          (ticks),
        .adc            (adc),
        .rd_en          (rd_en),
        .ch_ad_diag     (ch_ad_diag),
        .acq_dgdad_en   (acq_dgdad_en),
        .ch_ad_value    (ch_ad_value),
        .value_upd      (value_upd),
        .ad_acq_cpl     (ad_acq_cpl)
    );

    // serial interface to the converter
    adc_spi_rd u_adc_spi_rd (
        .clk_sys   (clk_sys),
        .rst_sys_n (rst_sys_n),
        .rd_en     (rd_en),
        .spi_sdo   (spi_sdo),
        .spi_cs_n  (spi_cs_n),
        .spi_sclk  (spi_sclk),
        .adc       (adc)
    );

endmodule

`default_nettype wire

/* src/adc_spi_rd.sv */
`timescale 1ns/1ps
`default_nettype none

module adc_spi_rd import adacq_pkg::*; (
    input  logic    clk_sys,
    input  logic    rst_sys_n,
    input  logic    rd_en,
    input  logic    spi_sdo,
    output logic    spi_cs_n,
    output logic    spi_sclk,
    output adc_rd_t adc
);

    // frame phases, guard cycles around the sclk burst
    typedef enum logic [1:0] {
        SPI_IDLE,
        SPI_LEAD,
        SPI_SHIFT,
        SPI_TRAIL
    } spi_state_e;

    spi_state_e           state_q;
    logic [SPI_HC_W-1:0]  half_cnt;
    logic [BIT_CNT_W-1:0] bit_cnt;
    logic [ADC_W-1:0]     shift_q;
    logic [ADC_W-1:0]     data_q;
    logic                 busy_q;
    logic                 dval_q;
    logic                 half_end;
    logic                 last_bit;

    assign half_end = (half_cnt == SPI_HC_W'(SPI_HALF - 1));
    assign last_bit = (bit_cnt == BIT_CNT_W'(ADC_W - 1));

    // ------------------------------------------------------------
    // frame control
    // ------------------------------------------------------------
    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            state_q  <= SPI_IDLE;
            half_cnt <= '0;
            bit_cnt  <= '0;
            spi_cs_n <= 1'b1;
            spi_sclk <= 1'b0;
            busy_q   <= 1'b0;
            dval_q   <= 1'b0;
        end else begin
            dval_q <= 1'b0;
            case (state_q)
                // requests while busy never reach here
                SPI_IDLE: begin
                    if (rd_en) begin
                        state_q  <= SPI_LEAD;
                        spi_cs_n <= 1'b0;
                        busy_q   <= 1'b1;
                    end
                end
                // cs setup before the first edge
                SPI_LEAD: begin
                    state_q  <= SPI_SHIFT;
                    half_cnt <= '0;
                    bit_cnt  <= '0;
                end
                SPI_SHIFT: begin
                    if (half_end) begin
                        half_cnt <= '0;
                        spi_sclk <= ~spi_sclk;
                        // falling edge closes a bit
                        if (spi_sclk) begin
                            if (last_bit) begin
                                state_q <= SPI_TRAIL;
                            end else begin
                                bit_cnt <= bit_cnt + 1'b1;
                            end
                        end
                    end else begin
                        half_cnt <= half_cnt + 1'b1;
                    end
                end
                // cs hold, then release with the result
                SPI_TRAIL: begin
                    state_q  <= SPI_IDLE;
                    spi_cs_n <= 1'b1;
                    busy_q   <= 1'b0;
                    dval_q   <= 1'b1;
                end
                default: begin
                    state_q <= SPI_IDLE;
                end
            endcase
        end
    end

    // ------------------------------------------------------------
    // shift register
    // ------------------------------------------------------------
    // msb first, sampled as sclk rises
    always_ff @(posedge clk_sys) begin
        if (state_q == SPI_SHIFT && half_end && !spi_sclk) begin
            shift_q <= {shift_q[ADC_W-2:0], spi_sdo};
        end
        if (state_q == SPI_TRAIL) begin
            data_q <= shift_q;
        end
    end

    assign adc = '{busy: busy_q, dval: dval_q, data: data_q};

endmodule

`default_nettype wire

/* src/chan_acq_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module chan_acq_ctrl import adacq_pkg::*; (
    input  logic             clk_sys,
    input  logic             rst_sys_n,
    input  logic             pw_on_en,
    input  logic             cal_model_en,
    input  logic             cfg_chn_enable,
    input  tick_bus_t        ticks,
    input  adc_rd_t          adc,
    output logic             rd_en,
    output logic             ch_ad_diag,
    output logic             acq_dgdad_en,
    output logic [ADC_W-1:0] ch_ad_value,
    output logic             value_upd,
    output logic             ad_acq_cpl
);

    acq_state_e       state_q;
    acq_state_e       state_d;
    logic [DLY_W-1:0] dly_cnt;
    logic             dly_done;
    // pending diagnostic request
    logic             diag_req;
    // current or previous conversion was on the diag path
    logic             sw_flag;
    logic             acq_go;
    logic             conv_ok;

    // downstream diag logic gets a straight copy
    assign acq_dgdad_en = ch_ad_diag;

    // ------------------------------------------------------------
    // state machine
    // ------------------------------------------------------------
    // trigger only counts when the reader is free
    assign acq_go = ticks.acq_trig && !adc.busy && (cfg_chn_enable || cal_model_en);

    // long settle after any mux change
    assign dly_done = sw_flag ? (dly_cnt == DLY_W'(RD_SW_DLY))
                              : (dly_cnt == DLY_W'(RD_AD_DLY));

    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (pw_on_en) begin
                    state_d = ACQ_WAIT;
                end
            end
            ACQ_WAIT: begin
                if (acq_go) begin
                    state_d = CH_SW;
                end
            end
            // single cycle, mux already settled by AD_DONE
            CH_SW: begin
                state_d = DLY_RD;
            end
            DLY_RD: begin
                if (dly_done) begin
                    state_d = AD_RDY;
                end
            end
            AD_RDY: begin
                state_d = RD_ADC;
            end
            // wait for end of spi frame
            RD_ADC: begin
                if (adc.dval) begin
                    state_d = AD_DONE;
                end
            end
            AD_DONE: begin
                state_d = ACQ_WAIT;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    // settling counter, cleared outside DLY_RD
    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            dly_cnt <= '0;
        end else if (state_q == DLY_RD) begin
            dly_cnt <= dly_cnt + 1'b1;
        end else begin
            dly_cnt <= '0;
        end
    end

    // ------------------------------------------------------------
    // diagnostic mux control
    // ------------------------------------------------------------
    // new request wins over the clear at AD_DONE
    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            diag_req <= 1'b0;
        end else if (ticks.diag_due) begin
            diag_req <= 1'b1;
        end else if (state_q == AD_DONE) begin
            diag_req <= 1'b0;
        end
    end

    // mux select and switch flag only move between conversions
    // calibration pins the mux on the channel
    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            ch_ad_diag <= 1'b0;
            sw_flag    <= 1'b0;
        end else if (cal_model_en) begin
            ch_ad_diag <= 1'b0;
            sw_flag    <= 1'b0;
        end else if (state_q == AD_DONE) begin
            ch_ad_diag <= diag_req;
            // covers the diag read and the switch back
            sw_flag    <= diag_req || ch_ad_diag;
        end
    end

    // ------------------------------------------------------------
    // read request and result
    // ------------------------------------------------------------
    // one cycle after AD_RDY
    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            rd_en <= 1'b0;
        end else begin
            rd_en <= (state_q == AD_RDY);
        end
    end

    // only clean channel conversions reach the output
    assign conv_ok = (state_q == RD_ADC) && adc.dval && !sw_flag;

    // negative codes clip to zero, sign bit dropped otherwise
    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            ch_ad_value <= '0;
            value_upd   <= 1'b0;
        end else begin
            value_upd <= conv_ok;
            if (conv_ok) begin
                ch_ad_value <= adc.data[ADC_W-1] ? {1'b0, adc.data[ADC_W-2:0]} : '0;
            end
        end
    end

    // sticky after the first finished conversion
    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            ad_acq_cpl <= 1'b0;
        end else if (state_q == AD_DONE) begin
            ad_acq_cpl <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* src/acq_timebase.sv */
`timescale 1ns/1ps
`default_nettype none

module acq_timebase import adacq_pkg::*; (
    input  logic      clk_sys,
    input  logic      rst_sys_n,
    input  logic      pw_on_en,
    output tick_bus_t ticks
);

    logic [TICK_W-1:0]     tick_cnt;
    logic [ACQ_CNT_W-1:0]  acq_cnt;
    logic [DIAG_CNT_W-1:0] diag_cnt;
    logic                  tick_wrap;
    logic                  acq_wrap;
    logic                  diag_wrap;

    // ------------------------------------------------------------
    // tick divider
    // ------------------------------------------------------------
    assign tick_wrap = (tick_cnt == TICK_W'(TICK_DIV));

    // free running, independent of power-on
    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            tick_cnt <= '0;
        end else if (tick_wrap) begin
            tick_cnt <= '0;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    // ------------------------------------------------------------
    // period counters
    // ------------------------------------------------------------
    // wrap on the last tick of each period
    assign acq_wrap  = pw_on_en && tick_wrap &&
                       (acq_cnt == ACQ_CNT_W'(ACQ_PERIOD_TICKS - 1));
    assign diag_wrap = pw_on_en && tick_wrap &&
                       (diag_cnt == DIAG_CNT_W'(DIAG_PERIOD_TICKS - 1));

    // acquisition period, held at zero while powered down
    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            acq_cnt <= '0;
        end else if (!pw_on_en) begin
            acq_cnt <= '0;
        end else if (tick_wrap) begin
            acq_cnt <= acq_wrap ? '0 : acq_cnt + 1'b1;
        end
    end

    // diagnostic period, same gating
    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            diag_cnt <= '0;
        end else if (!pw_on_en) begin
            diag_cnt <= '0;
        end else if (tick_wrap) begin
            diag_cnt <= diag_wrap ? '0 : diag_cnt + 1'b1;
        end
    end

    // ------------------------------------------------------------
    // registered strobes
    // ------------------------------------------------------------
    // one cycle behind the wrap condition
    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            ticks <= '0;
        end else begin
            ticks.acq_trig <= acq_wrap;
            ticks.diag_due <= diag_wrap;
        end
    end

endmodule

`default_nettype wire

/* src/adacq_pkg.sv */
`default_nettype none

package adacq_pkg;

    // ------------------------------------------------------------
    // timebase constants
    // ------------------------------------------------------------
    // clk_sys cycles per tick, minus one
    localparam int unsigned TICK_DIV          = 4;
    // ticks between acquisition triggers
    localparam int unsigned ACQ_PERIOD_TICKS  = 8;
    // ticks between diagnostic requests
    localparam int unsigned DIAG_PERIOD_TICKS = 60;

    // settling delays in clk_sys cycles
    localparam int unsigned RD_AD_DLY         = 6;
    localparam int unsigned RD_SW_DLY         = 30;

    // adc word and serial clock
    localparam int unsigned ADC_W             = 16;
    // clk_sys cycles per sclk half period
    localparam int unsigned SPI_HALF          = 2;

    // ------------------------------------------------------------
    // derived counter widths
    // ------------------------------------------------------------
    localparam int unsigned TICK_W     = $clog2(TICK_DIV + 1);
    localparam int unsigned ACQ_CNT_W  = $clog2(ACQ_PERIOD_TICKS);
    localparam int unsigned DIAG_CNT_W = $clog2(DIAG_PERIOD_TICKS);
    // sized for the longer of the two delays
    localparam int unsigned DLY_W      = $clog2(RD_SW_DLY + 1);
    localparam int unsigned BIT_CNT_W  = $clog2(ADC_W);
    localparam int unsigned SPI_HC_W   = $clog2(SPI_HALF + 1);

    // ------------------------------------------------------------
    // types
    // ------------------------------------------------------------
    // one-hot acquisition controller states
    typedef enum logic [6:0] {
        IDLE     = 7'b000_0001,
        ACQ_WAIT = 7'b000_0010,
        CH_SW    = 7'b000_0100,
        DLY_RD   = 7'b000_1000,
        AD_RDY   = 7'b001_0000,
        RD_ADC   = 7'b010_0000,
        AD_DONE  = 7'b100_0000
    } acq_state_e;

    // timebase strobes, both single cycle
    typedef struct packed {
        logic acq_trig;
        logic diag_due;
    } tick_bus_t;

    // spi reader result, data qualified by dval
    typedef struct packed {
        logic             busy;
        logic             dval;
        logic [ADC_W-1:0] data;
    } adc_rd_t;

endpackage

`default_nettype wire
